//--- verilog/vreader_pkg.sv
// shared widths, AXI constants, enums and beat attribute record; import into each vreader module
package vreader_pkg;

  // --------------------------------------------------
  // bus and buffer widths
  // --------------------------------------------------
  localparam int AXI_AW   = 32;  // byte address
  localparam int AXI_DW   = 64;  // R data bus
  localparam int AXI_NB   = 8;   // bytes per beat
  localparam int AXI_OFSW = 3;   // byte offset within a beat
  localparam int AXI_BCW  = 4;   // 0..8 bytes per beat
  localparam int LINE_DW  = 32;  // output line
  localparam int LINE_NB  = 4;
  localparam int LINE_BCW = 3;   // 0..4 bytes per line
  localparam int NBW      = 10;  // command byte count, 1..512
  localparam int BUF_BCW  = 4;   // aligner fill, up to 12

  // --------------------------------------------------
  // constant AR fields
  // --------------------------------------------------
  localparam logic [2:0] AR_SIZE       = 3'b011;   // 8 bytes per beat
  localparam logic [1:0] AR_BURST_INCR = 2'b01;
  localparam logic [3:0] AR_CACHE      = 4'b1111;  // write-back, allocate
  localparam logic [2:0] AR_PROT       = 3'b010;   // data, non-secure, unprivileged
  localparam logic [3:0] AR_ID         = 4'h0;     // single id keeps responses in order

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // R-side sequencing
  typedef enum logic [1:0] {
    IDLE_RCH,
    BEAT0_RCH,  // first beat of a multi-beat burst
    DATA_RCH    // middle and final beats, or the only beat
  } rch_state_e;

  // per-burst info handed from AR side to R side
  typedef struct packed {
    logic [AXI_OFSW-1:0] ofs;         // start offset in first beat
    logic [7:0]          len;         // arlen
    logic [AXI_BCW-1:0]  first_bcnt;
    logic [AXI_BCW-1:0]  last_bcnt;
  } beat_attr_t;

endpackage

//--- verilog/vreader_cmd_intake.sv
// command queue and burst setup; issues one AR per command and queues its beat attributes
`timescale 1ns/1ps

module vreader_cmd_intake import vreader_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  logic [AXI_AW-1:0]  cmd_addr,
  input  logic [NBW-1:0]     cmd_num_bytes,
  output logic               arvalid,
  input  logic               arready,
  output logic [AXI_AW-1:0]  araddr,
  output logic [7:0]         arlen,
  output logic [2:0]         arsize,
  output logic [1:0]         arburst,
  output logic [3:0]         arid,
  output logic [3:0]         arcache,
  output logic [2:0]         arprot,
  output logic               attr_valid,
  input  logic               attr_ready,
  output beat_attr_t         attr
);

  // --------------------------------------------------
  // command queue, 2 deep
  // --------------------------------------------------
  logic [AXI_AW-1:0]  cq_addr [2];
  logic [NBW-1:0]     cq_nb [2];
  logic               cq_wr, cq_rd;
  logic [1:0]         cq_cnt;
  logic               cq_push, load;

  assign cmd_ready = (cq_cnt != 2'd2);
  assign cq_push   = cmd_valid & cmd_ready;

  always_ff @(posedge clk) begin
    if (cq_push) begin
      cq_addr[cq_wr] <= cmd_addr;
      cq_nb[cq_wr]   <= cmd_num_bytes;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cq_wr  <= 1'b0;
      cq_rd  <= 1'b0;
      cq_cnt <= 2'd0;
    end else begin
      if (cq_push) cq_wr <= ~cq_wr;
      if (load)    cq_rd <= ~cq_rd;
      cq_cnt <= cq_cnt + {1'b0, cq_push} - {1'b0, load};
    end
  end

  // --------------------------------------------------
  // burst attributes from queue head
  // --------------------------------------------------
  logic [AXI_AW-1:0]   hd_addr;
  logic [NBW-1:0]      hd_nb, rem_nb;
  logic [AXI_BCW-1:0]  room;
  beat_attr_t          calc;

  assign hd_addr = cq_addr[cq_rd];
  assign hd_nb   = cq_nb[cq_rd];

  always_comb begin
    calc.ofs        = hd_addr[AXI_OFSW-1:0];
    room            = AXI_BCW'(AXI_NB) - {1'b0, calc.ofs};  // bytes left in first beat
    calc.first_bcnt = (hd_nb <= NBW'(room)) ? hd_nb[AXI_BCW-1:0] : room;
    rem_nb          = hd_nb - NBW'(calc.first_bcnt);
    // extra beats, rounded up
    calc.len        = {1'b0, rem_nb[NBW-1:AXI_OFSW]} + {7'd0, |rem_nb[AXI_OFSW-1:0]};
    calc.last_bcnt  = (rem_nb[AXI_OFSW-1:0] == '0) ? AXI_BCW'(AXI_NB)
                                                    : {1'b0, rem_nb[AXI_OFSW-1:0]};
  end

  // --------------------------------------------------
  // AR register and attribute queue
  // --------------------------------------------------
  beat_attr_t  aq_mem [2];
  logic        aq_wr, aq_rd;
  logic [1:0]  aq_cnt;
  logic        aq_pop;

  // both sides need room, keeps AR order == attr order
  assign load   = (cq_cnt != 2'd0) & (~arvalid | arready) & (aq_cnt != 2'd2);
  assign aq_pop = attr_valid & attr_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) arvalid <= 1'b0;
    else if (load) arvalid <= 1'b1;
    else if (arready) arvalid <= 1'b0;  // accepted, nothing new
  end

  always_ff @(posedge clk) begin
    if (load) begin
      araddr        <= hd_addr;  // unaligned address as given
      arlen         <= calc.len;
      aq_mem[aq_wr] <= calc;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aq_wr  <= 1'b0;
      aq_rd  <= 1'b0;
      aq_cnt <= 2'd0;
    end else begin
      if (load)   aq_wr <= ~aq_wr;
      if (aq_pop) aq_rd <= ~aq_rd;
      aq_cnt <= aq_cnt + {1'b0, load} - {1'b0, aq_pop};
    end
  end

  assign attr_valid = (aq_cnt != 2'd0);
  assign attr       = aq_mem[aq_rd];

  assign arsize  = AR_SIZE;
  assign arburst = AR_BURST_INCR;
  assign arid    = AR_ID;
  assign arcache = AR_CACHE;
  assign arprot  = AR_PROT;

endmodule

//--- verilog/vreader_beat_seq.sv
// R-channel sequencer; tells the aligner which bytes of each beat to keep and drives rready
`timescale 1ns/1ps

module vreader_beat_seq import vreader_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 attr_valid,
  output logic                 attr_ready,
  input  beat_attr_t           attr,
  input  logic                 rvalid,
  input  logic                 rlast,
  output logic                 rready,
  input  logic [BUF_BCW-1:0]   free_bcnt,
  input  logic                 slot_free,
  output logic                 beat_valid,
  output logic [AXI_OFSW-1:0]  beat_ofs,
  output logic [AXI_BCW-1:0]   beat_bcnt,
  output logic                 beat_final,
  output logic                 beat_take
);

  rch_state_e  state, next_state, start_state;
  beat_attr_t  cur;         // attribute of burst in flight
  logic [7:0]  beats_left;  // beats after the current one
  logic        take, burst_end, pop;

  // --------------------------------------------------
  // per-beat offset and byte count
  // --------------------------------------------------
  assign beat_final = (state == DATA_RCH) && (beats_left == 8'd0);

  always_comb begin
    beat_ofs  = '0;
    beat_bcnt = '0;
    case (state)
      BEAT0_RCH: begin
        beat_ofs  = cur.ofs;
        beat_bcnt = cur.first_bcnt;
      end
      DATA_RCH: begin
        if (cur.len == 8'd0) begin  // one-beat burst, first and last at once
          beat_ofs  = cur.ofs;
          beat_bcnt = cur.first_bcnt;
        end else begin
          beat_bcnt = beat_final ? cur.last_bcnt : AXI_BCW'(AXI_NB);
        end
      end
      default: ;
    endcase
  end

  // stall when aligner is short of room, or resp slot is busy on the final beat
  assign rready = (state != IDLE_RCH) && (free_bcnt >= beat_bcnt) &&
                  (slot_free || !beat_final);

  assign take       = rvalid & rready;
  assign beat_valid = take;
  assign beat_take  = take;
  assign burst_end  = take & rlast;

  assign attr_ready  = (state == IDLE_RCH) || burst_end;
  assign pop         = attr_valid & attr_ready;
  assign start_state = (attr.len != 8'd0) ? BEAT0_RCH : DATA_RCH;

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      IDLE_RCH:  if (attr_valid) next_state = start_state;
      BEAT0_RCH: if (take) next_state = DATA_RCH;
      DATA_RCH:  if (burst_end) next_state = attr_valid ? start_state : IDLE_RCH;
      default:   next_state = IDLE_RCH;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE_RCH;
      beats_left <= 8'd0;
    end else begin
      state <= next_state;
      if (pop)
        beats_left <= attr.len;
      else if (take && beats_left != 8'd0)
        beats_left <= beats_left - 8'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) cur <= attr;
  end

endmodule

//--- verilog/vreader_byte_aligner.sv
// byte packer; appends kept beat bytes and offers 32-bit lines, flushing the tail of each burst
`timescale 1ns/1ps

module vreader_byte_aligner import vreader_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 beat_valid,
  input  logic [AXI_DW-1:0]    rdata,
  input  logic [AXI_OFSW-1:0]  beat_ofs,
  input  logic [AXI_BCW-1:0]   beat_bcnt,
  input  logic                 beat_final,
  output logic [BUF_BCW-1:0]   free_bcnt,
  output logic                 line_valid,
  input  logic                 line_ready,
  output logic [LINE_DW-1:0]   line_data,
  output logic [LINE_BCW-1:0]  line_bcnt,
  output logic                 line_last
);

  localparam int BNB = AXI_NB + LINE_NB;  // 12 byte buffer

  logic [8*BNB-1:0]    buf_q, buf_shift, buf_next, app;
  logic [BNB-1:0]      app_mask;
  logic [AXI_DW-1:0]   sel;
  logic [BUF_BCW-1:0]  fill_q, base_fill, fill_next;
  logic                done_q;  // final beat absorbed, tail still in buffer
  logic                take;

  // --------------------------------------------------
  // line offer
  // --------------------------------------------------
  assign line_valid = (fill_q >= BUF_BCW'(LINE_NB)) || (done_q && fill_q != '0);
  assign line_bcnt  = (fill_q >= BUF_BCW'(LINE_NB)) ? LINE_BCW'(LINE_NB)
                                                    : fill_q[LINE_BCW-1:0];
  assign line_last  = done_q && (fill_q <= BUF_BCW'(LINE_NB));
  assign line_data  = buf_q[LINE_DW-1:0];
  assign take       = line_valid & line_ready;

  // no room for the next burst until the tail is out
  assign free_bcnt  = done_q ? '0 : BUF_BCW'(BNB) - fill_q;

  // --------------------------------------------------
  // shift out and append
  // --------------------------------------------------
  always_comb begin
    sel       = rdata >> {beat_ofs, 3'b000};  // first kept byte to bit 0
    base_fill = take ? fill_q - {1'b0, line_bcnt} : fill_q;
    buf_shift = take ? buf_q >> {line_bcnt, 3'b000} : buf_q;
    app       = {{(8*LINE_NB){1'b0}}, sel} << {base_fill, 3'b000};
    app_mask  = ((BNB'(1) << beat_bcnt) - BNB'(1)) << base_fill;
    for (int i = 0; i < BNB; i++) begin
      buf_next[8*i +: 8] = (beat_valid && app_mask[i]) ? app[8*i +: 8]
                                                        : buf_shift[8*i +: 8];
    end
    fill_next = base_fill + (beat_valid ? beat_bcnt : '0);
  end

  always_ff @(posedge clk) begin
    buf_q <= buf_next;  // bytes above fill are don't-care
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_q <= '0;
      done_q <= 1'b0;
    end else begin
      fill_q <= fill_next;
      if (beat_valid && beat_final)
        done_q <= 1'b1;
      else if (take && line_last)  // burst fully drained
        done_q <= 1'b0;
    end
  end

endmodule

//--- verilog/vreader_load_buffer.sv
// two-entry line FIFO in front of the data port; builds the byte strobe on entry
`timescale 1ns/1ps

module vreader_load_buffer import vreader_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 line_valid,
  output logic                 line_ready,
  input  logic [LINE_DW-1:0]   line_data,
  input  logic [LINE_BCW-1:0]  line_bcnt,
  input  logic                 line_last,
  output logic                 data_valid,
  input  logic                 data_ready,
  output logic [LINE_DW-1:0]   data_data,
  output logic [LINE_NB-1:0]   data_strb,
  output logic                 data_last
);

  logic [LINE_DW-1:0]  mem_data [2];
  logic [LINE_NB-1:0]  mem_strb [2];
  logic                mem_last [2];
  logic [LINE_NB-1:0]  in_strb;
  logic                wr_ptr, rd_ptr, push, pop;
  logic [1:0]          cnt;

  // low line_bcnt bytes valid, always packed from byte 0
  assign in_strb = {LINE_NB{1'b1}} >> (LINE_NB - line_bcnt);

  assign line_ready = (cnt != 2'd2);
  assign data_valid = (cnt != 2'd0);
  assign push       = line_valid & line_ready;
  assign pop        = data_valid & data_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_data[wr_ptr] <= line_data;
      mem_strb[wr_ptr] <= in_strb;
      mem_last[wr_ptr] <= line_last;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      cnt    <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop)  rd_ptr <= ~rd_ptr;
      cnt <= cnt + {1'b0, push} - {1'b0, pop};
    end
  end

  assign data_data = mem_data[rd_ptr];
  assign data_strb = mem_strb[rd_ptr];
  assign data_last = mem_last[rd_ptr];

endmodule

//--- verilog/vreader_resp_track.sv
// per-burst response; keeps the first SLVERR/DECERR and holds one response for the port
`timescale 1ns/1ps

module vreader_resp_track import vreader_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        beat_take,
  input  logic [1:0]  rresp,
  input  logic        rlast,
  output logic        slot_free,
  output logic        resp_valid,
  input  logic        resp_ready,
  output axi_resp_e   resp_resp
);

  axi_resp_e  beat_resp, first_err;
  logic       err_seen, is_err;

  assign beat_resp = axi_resp_e'(rresp);
  assign is_err    = (beat_resp == RESP_SLVERR) || (beat_resp == RESP_DECERR);
  assign slot_free = ~resp_valid | resp_ready;  // empty or draining now

  // --------------------------------------------------
  // first error of the burst in flight
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_seen  <= 1'b0;
      first_err <= RESP_OKAY;
    end else if (beat_take) begin
      if (rlast)
        err_seen <= 1'b0;  // rearm for next burst
      else if (!err_seen && is_err) begin
        err_seen  <= 1'b1;
        first_err <= beat_resp;
      end
    end
  end

  // holding register, final beat is gated on slot_free upstream
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
      resp_resp  <= RESP_OKAY;
    end else if (beat_take && rlast) begin
      resp_valid <= 1'b1;
      resp_resp  <= err_seen ? first_err : beat_resp;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

endmodule

//--- verilog/axi_vreader.sv
// streaming AXI read loader top; one INCR burst per command, repacked into 32-bit lines
`timescale 1ns/1ps

module axi_vreader import vreader_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  // command port
  input  logic                cmd_valid,
  output logic                cmd_ready,
  input  logic [AXI_AW-1:0]   cmd_addr,
  input  logic [NBW-1:0]      cmd_num_bytes,
  // AXI AR channel
  output logic                arvalid,
  input  logic                arready,
  output logic [AXI_AW-1:0]   araddr,
  output logic [7:0]          arlen,
  output logic [2:0]          arsize,
  output logic [1:0]          arburst,
  output logic [3:0]          arid,
  output logic [3:0]          arcache,
  output logic [2:0]          arprot,
  // AXI R channel
  input  logic                rvalid,
  output logic                rready,
  input  logic [AXI_DW-1:0]   rdata,
  input  logic [1:0]          rresp,
  input  logic                rlast,
  // line output
  output logic                data_valid,
  input  logic                data_ready,
  output logic [LINE_DW-1:0]  data_data,
  output logic [LINE_NB-1:0]  data_strb,
  output logic                data_last,
  // per-command response
  output logic                resp_valid,
  input  logic                resp_ready,
  output logic [1:0]          resp_resp
);

  // --------------------------------------------------
  // internal paths
  // --------------------------------------------------
  logic                 attr_valid, attr_ready;
  beat_attr_t           attr;
  logic                 beat_valid, beat_final, beat_take;
  logic [AXI_OFSW-1:0]  beat_ofs;
  logic [AXI_BCW-1:0]   beat_bcnt;
  logic [BUF_BCW-1:0]   free_bcnt;
  logic                 slot_free;
  logic                 line_valid, line_ready, line_last;
  logic [LINE_DW-1:0]   line_data;
  logic [LINE_BCW-1:0]  line_bcnt;

  vreader_cmd_intake u_cmd_intake (
    .clk, .rst_n,
    .cmd_valid, .cmd_ready, .cmd_addr, .cmd_num_bytes,
    .arvalid, .arready, .araddr, .arlen, .arsize, .arburst, .arid, .arcache, .arprot,
    .attr_valid, .attr_ready, .attr
  );

  vreader_beat_seq u_beat_seq (
    .clk, .rst_n,
    .attr_valid, .attr_ready, .attr,
    .rvalid, .rlast, .rready,
    .free_bcnt, .slot_free,
    .beat_valid, .beat_ofs, .beat_bcnt, .beat_final, .beat_take
  );

  vreader_byte_aligner u_byte_aligner (
    .clk, .rst_n,
    .beat_valid, .rdata, .beat_ofs, .beat_bcnt, .beat_final,
    .free_bcnt,
    .line_valid, .line_ready, .line_data, .line_bcnt, .line_last
  );

  vreader_load_buffer u_load_buffer (
    .clk, .rst_n,
    .line_valid, .line_ready, .line_data, .line_bcnt, .line_last,
    .data_valid, .data_ready, .data_data, .data_strb, .data_last
  );

  vreader_resp_track u_resp_track (
    .clk, .rst_n,
    .beat_take, .rresp, .rlast,
    .slot_free,
    .resp_valid, .resp_ready, .resp_resp
  );

endmodule

//--- tests/axi_vreader_tb.sv
// testbench for axi_vreader; random commands against an AXI slave model and a byte-level reference
`timescale 1ns/1ps

module axi_vreader_tb import vreader_pkg::*; ();

  localparam logic [31:0] LFSR_POLY = 32'h80200003;  // taps 32,22,2,1
  localparam int CMD_LIMIT   = 2000;    // cycles to wait for cmd_ready
  localparam int DRAIN_LIMIT = 200000;  // cycles to empty all queues

  logic clk, rst_n;
  logic cmd_valid, cmd_ready;
  logic [AXI_AW-1:0] cmd_addr, araddr;
  logic [NBW-1:0] cmd_num_bytes;
  logic arvalid, arready, rvalid, rready, rlast;
  logic [7:0] arlen;
  logic [2:0] arsize, arprot;
  logic [1:0] arburst, rresp, resp_resp;
  logic [3:0] arid, arcache;
  logic [AXI_DW-1:0] rdata;
  logic data_valid, data_ready, data_last, resp_valid, resp_ready;
  logic [LINE_DW-1:0] data_data;
  logic [LINE_NB-1:0] data_strb;

  logic [31:0] lfsr = 32'h11277cbc;
  bit stress = 1'b0;           // set for random consumer stalls without command gaps
  bit timed_out = 1'b0;        // some wait ran out of cycles
  int errs [1:5];
  int n_cmds = 0, n_ars = 0, n_lines = 0, n_resps = 0;

  // reference queues
  logic [31:0] exp_ar_addr_q [$];
  int          exp_ar_len_q [$];
  logic [31:0] exp_data_q [$];
  logic [3:0]  exp_strb_q [$];
  bit          exp_last_q [$];
  logic [1:0]  exp_resp_q [$];   // filled by slave model at burst end
  // slave model state
  logic [31:0] ar_addr_q [$];
  int          ar_len_q [$];
  int          r_idx = 0;        // beat being presented
  bit          r_err = 1'b0;     // SLVERR seen in current burst

  axi_vreader axi_vreader_i (.*);

  always #20 clk = ~clk;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] rnd(input int nbits);
    logic [31:0] r;
    logic b;
    int i;
    r = '0;
    for (i = 0; i < nbits; i++) begin  // one LFSR step per bit
      b = lfsr[0];
      lfsr = {1'b0, lfsr[31:1]} ^ (b ? LFSR_POLY : 32'h0);
      r = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic logic [7:0] byte_at(input logic [31:0] a);
    logic [31:0] p;
    p = a * 32'd7 + 32'd3;  // memory content rule
    return p[7:0];
  endfunction

  function automatic logic [63:0] beat_data(input logic [31:0] base);
    logic [63:0] d;
    int k;
    for (k = 0; k < 8; k++) d[8*k +: 8] = byte_at(base + 32'(k));
    return d;
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  function automatic bit drained();
    return exp_ar_addr_q.size() == 0 && ar_addr_q.size() == 0 &&
           exp_data_q.size() == 0 && exp_resp_q.size() == 0;
  endfunction

  function automatic string verdict(input int tid);
    return (errs[tid] == 0) ? "ok" : $sformatf("failed, %0d errors", errs[tid]);
  endfunction

  task automatic check(input int tid, input string name, input logic [31:0] got,
                       input logic [31:0] exp);
    if (got !== exp) begin
      errs[tid]++;
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic flag_failure(input int tid, input string msg);
    errs[tid]++;
    $display("test %0d: %s", tid, msg);
  endtask

  task automatic note_timeout(input int tid, input string what);
    errs[tid]++;
    timed_out = 1'b1;
    $display("timeout: %s", what);
  endtask

  // --------------------------------------------------
  // AXI slave model accepting AR and returning R beats in order
  // --------------------------------------------------
  always @(posedge clk) begin : axi_slave
    logic [31:0] a;
    int tid;
    tid = stress ? 5 : 2;
    if (arvalid && arready) begin
      n_ars++;
      if (exp_ar_addr_q.size() == 0) flag_failure(tid, "AR issued with no command pending");
      else begin
        check(tid, "araddr", araddr, exp_ar_addr_q[0]);
        check(tid, "arlen", 32'(arlen), 32'(exp_ar_len_q[0]));
        check(tid, "arsize", 32'(arsize), 32'd3);     // 8 bytes per beat
        check(tid, "arburst", 32'(arburst), 32'd1);   // INCR
        check(tid, "arid", 32'(arid), 32'(AR_ID));
        check(tid, "arcache", 32'(arcache), 32'(AR_CACHE));
        check(tid, "arprot", 32'(arprot), 32'(AR_PROT));
        void'(exp_ar_addr_q.pop_front());
        void'(exp_ar_len_q.pop_front());
      end
      ar_addr_q.push_back(araddr);
      ar_len_q.push_back(int'(arlen));
    end
    if (rvalid && rready) begin
      if (rresp == 2'b10) r_err = 1'b1;
      if (r_idx == ar_len_q[0]) begin  // burst done so its response is known
        exp_resp_q.push_back(r_err ? 2'b10 : 2'b00);
        r_err = 1'b0;
        r_idx = 0;
        void'(ar_addr_q.pop_front());
        void'(ar_len_q.pop_front());
      end else begin
        r_idx++;
      end
    end
    if (!rvalid || rready) begin  // channel free for a new beat
      if (ar_addr_q.size() != 0 && rnd(2) != 0) begin
        a = ar_addr_q[0];
        rdata  <= beat_data({a[31:3], 3'b000} + 32'(8 * r_idx));
        rresp  <= (rnd(4) == 0) ? 2'b10 : 2'b00;  // about 1 in 16 SLVERR
        rlast  <= (r_idx == ar_len_q[0]);
        rvalid <= 1'b1;
      end else begin
        rvalid <= 1'b0;
      end
    end
    arready <= (rnd(2) != 0);
  end

  // --------------------------------------------------
  // line and response consumer
  // --------------------------------------------------
  always @(posedge clk) begin : consumer
    int tid;
    logic [31:0] m;
    tid = stress ? 5 : 3;
    if (data_valid && data_ready) begin
      n_lines++;
      if (exp_data_q.size() == 0) flag_failure(tid, "line arrived with none expected");
      else begin
        m = lane_mask(exp_strb_q[0]);  // lanes above the strobe are don't-care
        check(tid, "data_strb", 32'(data_strb), 32'(exp_strb_q[0]));
        check(tid, "data_data", data_data & m, exp_data_q[0] & m);
        check(tid, "data_last", 32'(data_last), 32'(exp_last_q[0]));
        void'(exp_data_q.pop_front());
        void'(exp_strb_q.pop_front());
        void'(exp_last_q.pop_front());
      end
    end
    tid = stress ? 5 : 4;
    if (resp_valid && resp_ready) begin
      n_resps++;
      if (exp_resp_q.size() == 0) flag_failure(tid, "response arrived with none expected");
      else begin
        check(tid, "resp_resp", 32'(resp_resp), 32'(exp_resp_q[0]));
        void'(exp_resp_q.pop_front());
      end
    end
    data_ready <= stress ? (rnd(1) != 0) : 1'b1;
    resp_ready <= stress ? (rnd(2) == 0) : 1'b1;  // tight resp slot in phase B
  end

  // --------------------------------------------------
  // command driver and reference model
  // --------------------------------------------------
  task automatic pick_cmd(output logic [31:0] addr, output int n);
    addr = rnd(32);
    if (rnd(2) == 0) addr[2:0] = 3'd0;  // some beat aligned
    if (rnd(1) != 0) n = 1 + int'(rnd(4));
    else n = 1 + int'(rnd(9));          // up to 512 bytes
  endtask

  task automatic send_cmd(input logic [31:0] addr, input int n, input bit gap);
    int t, i, k;
    bit accepted;
    logic [31:0] w;
    logic [3:0] s;
    if (gap) begin
      cmd_valid <= 1'b0;
      repeat (rnd(3)) @(posedge clk);
    end
    cmd_valid     <= 1'b1;
    cmd_addr      <= addr;
    cmd_num_bytes <= NBW'(n);
    t = 0;
    do begin
      @(posedge clk);
      t++;
      accepted = cmd_ready;
    end while (!accepted && t < CMD_LIMIT);
    if (!accepted) begin
      note_timeout(stress ? 5 : 2, "command port never became ready");
    end else begin
      n_cmds++;
      exp_ar_addr_q.push_back(addr);
      exp_ar_len_q.push_back((int'(addr[2:0]) + n + 7) / 8 - 1);
      for (i = 0; i < n; i += 4) begin  // bytes A..A+n-1 packed from lane 0
        w = '0;
        s = '0;
        for (k = 0; k < 4; k++) begin
          if (i + k < n) begin
            w[8*k +: 8] = byte_at(addr + 32'(i + k));
            s[k] = 1'b1;
          end
        end
        exp_data_q.push_back(w);
        exp_strb_q.push_back(s);
        exp_last_q.push_back(i + 4 >= n);
      end
    end
  endtask

  task automatic drain_all(input int tid, input string what);
    int t;
    t = 0;
    while (!drained() && t < DRAIN_LIMIT) begin
      @(posedge clk);
      t++;
    end
    if (!drained()) note_timeout(tid, what);
    else repeat (20) @(posedge clk);  // idle window catches stray lines or responses
  endtask

  initial begin : main
    logic [31:0] a;
    int n, i, total;
    clk = 1'b0;
    rst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd_addr = '0;
    cmd_num_bytes = '0;
    arready = 1'b0;
    rvalid = 1'b0;
    rdata = '0;
    rresp = 2'b00;
    rlast = 1'b0;
    data_ready = 1'b0;
    resp_ready = 1'b0;
    for (i = 1; i <= 5; i++) errs[i] = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    check(1, "cmd_ready", 32'(cmd_ready), 32'd1);
    check(1, "arvalid", 32'(arvalid), 32'd0);
    check(1, "rready", 32'(rready), 32'd0);
    check(1, "data_valid", 32'(data_valid), 32'd0);
    check(1, "resp_valid", 32'(resp_valid), 32'd0);
    $display("test 1 reset state: %s", verdict(1));

    // phase A with gaps between commands and an always-ready consumer
    for (i = 0; i < 40 && !timed_out; i++) begin
      pick_cmd(a, n);
      send_cmd(a, n, 1'b1);
    end
    cmd_valid <= 1'b0;
    if (!timed_out) drain_all(3, "phase A did not drain, lines or responses missing");
    $display("test 2 AR fields, %0d bursts: %s", n_ars, verdict(2));
    $display("test 3 line data and strobes, %0d lines: %s", n_lines, verdict(3));
    $display("test 4 responses, %0d responses: %s", n_resps, verdict(4));

    // phase B runs back-to-back with random stalls
    if (!timed_out) begin
      stress = 1'b1;
      for (i = 0; i < 200 && !timed_out; i++) begin
        pick_cmd(a, n);
        send_cmd(a, n, 1'b0);
      end
      cmd_valid <= 1'b0;
      if (!timed_out) drain_all(5, "phase B did not drain, lines or responses missing");
      $display("test 5 stalls, 200 back-to-back commands: %s", verdict(5));
    end

    total = 0;
    for (i = 1; i <= 5; i++) total += errs[i];
    $display("summary: %0d commands, %0d bursts, %0d lines, %0d responses, %0d errors",
             n_cmds, n_ars, n_lines, n_resps, total);
    if (total == 0) $display("Simulation finished: PASS");
    else $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- axi_vreader.f
verilog/vreader_pkg.sv
verilog/vreader_cmd_intake.sv
verilog/vreader_beat_seq.sv
verilog/vreader_byte_aligner.sv
verilog/vreader_load_buffer.sv
verilog/vreader_resp_track.sv
verilog/axi_vreader.sv
tests/axi_vreader_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator and run; status follows the testbench verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module axi_vreader_tb \
  -f axi_vreader.f -o vsim &&
  ./obj_dir/vsim | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
  echo "run_sim: passed" ||
  { echo "run_sim: failed"; exit 1; }
